/* source/chdr_rx_consts.svh */
/* Widths and sizes for the CHDR receive path. Only 64-bit CHDR is supported,
   and NUM_PORTS must equal 2**PORT_W for the round-robin pointer to wrap. */

`ifndef CHDR_RX_CONSTS_SVH
`define CHDR_RX_CONSTS_SVH

// CHDR word width in bits
`define CHDR_W 64

// Sample width and samples per payload beat
`define ITEM_W 32
`define NIPC 2

// Output ports and the bits to index them
`define NUM_PORTS 4
`define PORT_W 2

// Sideband records a parser may hold ahead of its payload
`define CTX_FIFO_DEPTH 4

`endif

/* source/chdr_rx_pkg.sv */
/* Types and header field helpers for the CHDR receive path.
   Field positions assume the 64-bit header layout. */

package chdr_rx_pkg;

  `include "chdr_rx_consts.svh"

  typedef logic [`CHDR_W-1:0] chdr_word_t;
  typedef logic [`NIPC-1:0] item_keep_t;
  typedef logic [63:0] timestamp_t;
  typedef logic [`PORT_W-1:0] port_idx_t;
  typedef logic [15:0] chdr_len_t;
  typedef logic [4:0] num_mdata_t;
  typedef logic [2:0] pkt_type_t;

  // Data packet carrying a timestamp word
  localparam pkt_type_t PKT_DATA_TS = 3'd7;

  typedef enum logic [1:0] {
    ROUTE_HEADER,
    ROUTE_TIMESTAMP,
    ROUTE_METADATA,
    ROUTE_PAYLOAD
  } router_state_t;

  typedef enum logic [1:0] {
    CTX_HEADER,
    CTX_TIMESTAMP,
    CTX_METADATA
  } parser_state_t;

  // --------------------------------------------------
  // Header field extraction
  // --------------------------------------------------

  // Low bits of the destination endpoint select the port
  function automatic port_idx_t hdr_port(chdr_word_t hdr);
    return hdr[`PORT_W-1:0];
  endfunction

  function automatic logic hdr_has_time(chdr_word_t hdr);
    return pkt_type_t'(hdr[55:53]) == PKT_DATA_TS;
  endfunction

  function automatic num_mdata_t hdr_num_mdata(chdr_word_t hdr);
    return hdr[52:48];
  endfunction

  // Length in bytes, header included
  function automatic chdr_len_t hdr_length(chdr_word_t hdr);
    return hdr[31:16];
  endfunction

endpackage

/* source/stream_ifs.sv */
/* AXI-Stream style buses between router, parsers and arbiter.
   Sources hold valid and data until the beat transfers. */

`timescale 1ns/1ps

// Payload words with per-sample keep
interface payload_if import chdr_rx_pkg::*; ();
  chdr_word_t tdata;
  item_keep_t tkeep;
  logic tlast;
  logic tvalid;
  logic tready;

  modport source (output tdata, tkeep, tlast, tvalid, input tready);
  modport sink (input tdata, tkeep, tlast, tvalid, output tready);
endinterface

// Header, timestamp and metadata words
interface context_if import chdr_rx_pkg::*; ();
  chdr_word_t tdata;
  logic tlast;
  logic tvalid;
  logic tready;

  modport source (output tdata, tlast, tvalid, input tready);
  modport sink (input tdata, tlast, tvalid, output tready);
endinterface

// Payload with sideband held for the whole packet
interface sideband_if import chdr_rx_pkg::*; ();
  chdr_word_t tdata;
  item_keep_t tkeep;
  logic tlast;
  logic tvalid;
  logic tready;
  timestamp_t timestamp;
  logic has_time;
  logic eov;
  logic eob;

  modport source (output tdata, tkeep, tlast, tvalid, timestamp, has_time, eov, eob,
                  input tready);
  modport sink (input tdata, tkeep, tlast, tvalid, timestamp, has_time, eov, eob,
                output tready);
endinterface

/* source/chdr_port_router.sv */
/* Lengths are trusted and every packet must carry at least one payload word.
   Only data packets with or without timestamp are understood. */

`timescale 1ns/1ps
`include "chdr_rx_consts.svh"

module chdr_port_router import chdr_rx_pkg::*; (
  input  logic       axis_data_clk,
  input  logic       axis_data_rst,
  input  chdr_word_t s_tdata,
  input  logic       s_tlast,
  input  logic       s_tvalid,
  output logic       s_tready,
  context_if.source  ctx [`NUM_PORTS],
  payload_if.source  pay [`NUM_PORTS]
);

  localparam int WORD_BYTES = `CHDR_W / 8;
  localparam int ITEM_BYTES = `ITEM_W / 8;
  localparam int OFS_W = $clog2(WORD_BYTES);

  router_state_t state;
  logic          route_en;
  port_idx_t     port_q;
  num_mdata_t    mdata_q;
  chdr_len_t     len_q;

  port_idx_t  sel;
  logic       to_ctx;
  logic       ctx_last;
  item_keep_t keep_last;
  logic       beat;

  logic [`NUM_PORTS-1:0] ctx_ready;
  logic [`NUM_PORTS-1:0] pay_ready;

  // --------------------------------------------------
  // Steering
  // --------------------------------------------------

  // Header word picks its own port and later words use the latched one
  assign sel    = (state == ROUTE_HEADER) ? hdr_port(s_tdata) : port_q;
  assign to_ctx = (state != ROUTE_PAYLOAD);

  // Last context word depends on timestamp and metadata still to come
  always_comb begin
    case (state)
      ROUTE_HEADER:    ctx_last = !hdr_has_time(s_tdata) && (hdr_num_mdata(s_tdata) == '0);
      ROUTE_TIMESTAMP: ctx_last = (mdata_q == '0);
      ROUTE_METADATA:  ctx_last = (mdata_q == num_mdata_t'(1));
      default:         ctx_last = 1'b0;
    endcase
  end

  // Bytes in the final word; zero means the word is full
  always_comb begin : keep_calc
    logic [OFS_W-1:0] tail;
    tail = len_q[OFS_W-1:0];
    for (int i = 0; i < `NIPC; i++) begin
      keep_last[i] = (tail == '0) || (int'(tail) > i * ITEM_BYTES);
    end
  end

  assign s_tready = route_en && (to_ctx ? ctx_ready[sel] : pay_ready[sel]);
  assign beat     = s_tvalid && s_tready;

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
    assign ctx[p].tdata  = s_tdata;
    assign ctx[p].tlast  = ctx_last;
    assign ctx[p].tvalid = s_tvalid && route_en && to_ctx && (sel == port_idx_t'(p));
    assign ctx_ready[p]  = ctx[p].tready;

    assign pay[p].tdata  = s_tdata;
    assign pay[p].tkeep  = s_tlast ? keep_last : '1;
    assign pay[p].tlast  = s_tlast;
    assign pay[p].tvalid = s_tvalid && route_en && !to_ctx && (sel == port_idx_t'(p));
    assign pay_ready[p]  = pay[p].tready;
  end

  // --------------------------------------------------
  // Packet FSM
  // --------------------------------------------------

  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      state    <= ROUTE_HEADER;
      route_en <= 1'b0;
    end else begin
      route_en <= 1'b1;
      if (beat) begin
        case (state)
          ROUTE_HEADER: begin
            port_q  <= hdr_port(s_tdata);
            mdata_q <= hdr_num_mdata(s_tdata);
            len_q   <= hdr_length(s_tdata);
            if (hdr_has_time(s_tdata)) begin
              state <= ROUTE_TIMESTAMP;
            end else if (hdr_num_mdata(s_tdata) != '0) begin
              state <= ROUTE_METADATA;
            end else begin
              state <= ROUTE_PAYLOAD;
            end
          end
          ROUTE_TIMESTAMP: begin
            state <= (mdata_q != '0) ? ROUTE_METADATA : ROUTE_PAYLOAD;
          end
          ROUTE_METADATA: begin
            mdata_q <= mdata_q - num_mdata_t'(1);
            if (mdata_q == num_mdata_t'(1)) begin
              state <= ROUTE_PAYLOAD;
            end
          end
          default: begin
            // Payload runs until the input packet ends
            if (s_tlast) begin
              state <= ROUTE_HEADER;
            end
          end
        endcase
      end
    end
  end

  // A packet must not end before its payload starts
  a_last_in_payload: assert property (@(posedge axis_data_clk) disable iff (axis_data_rst)
    (beat && s_tlast) |-> (state == ROUTE_PAYLOAD))
    else $error("input packet ended inside its context words");

endmodule

/* source/sideband_fifo.sv */
/* One record per packet. Push and pop in the same cycle are allowed;
   output is the registered head entry, no fall-through. */

`timescale 1ns/1ps

module sideband_fifo import chdr_rx_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic       axis_data_clk,
  input  logic       axis_data_rst,
  input  timestamp_t i_timestamp,
  input  logic       i_has_time,
  input  logic       i_eov,
  input  logic       i_eob,
  input  logic       i_valid,
  output logic       i_ready,
  output timestamp_t o_timestamp,
  output logic       o_has_time,
  output logic       o_eov,
  output logic       o_eob,
  output logic       o_valid,
  input  logic       o_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef struct packed {
    timestamp_t timestamp;
    logic       has_time;
    logic       eov;
    logic       eob;
  } record_t;

  record_t            mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;

  assign i_ready = (count != CNT_W'(DEPTH));
  assign o_valid = (count != '0);
  assign push    = i_valid && i_ready;
  assign pop     = o_valid && o_ready;

  // Storage, no reset needed on the payload
  always_ff @(posedge axis_data_clk) begin
    if (push) begin
      mem[wr_ptr] <= '{i_timestamp, i_has_time, i_eov, i_eob};
    end
  end

  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      if (push && !pop) begin
        count <= count + CNT_W'(1);
      end else if (pop && !push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  assign o_timestamp = mem[rd_ptr].timestamp;
  assign o_has_time  = mem[rd_ptr].has_time;
  assign o_eov       = mem[rd_ptr].eov;
  assign o_eob       = mem[rd_ptr].eob;

  // A record offered while full would be lost
  a_no_push_full: assert property (@(posedge axis_data_clk) disable iff (axis_data_rst)
    i_valid |-> i_ready)
    else $error("sideband record pushed while full");

  // Payload must not end a packet that has no sideband
  a_no_pop_empty: assert property (@(posedge axis_data_clk) disable iff (axis_data_rst)
    o_ready |-> o_valid)
    else $error("sideband record popped while empty");

endmodule

/* source/context_parser.sv */
/* 64-bit CHDR only, timestamp follows the header word. Metadata is dropped.
   Context must be well formed; each packet needs a non-empty payload. */

`timescale 1ns/1ps
`include "chdr_rx_consts.svh"

module context_parser import chdr_rx_pkg::*; (
  input  logic       axis_data_clk,
  input  logic       axis_data_rst,
  context_if.sink    ctx,
  payload_if.sink    pay,
  sideband_if.source out
);

  parser_state_t state;
  logic          push_q;

  // Sideband for the packet being parsed
  timestamp_t ts_q;
  logic       has_time_q;
  logic       eov_q;
  logic       eob_q;

  logic fifo_in_ready;
  logic fifo_out_valid;
  logic fifo_pop;
  logic ctx_beat;

  // --------------------------------------------------
  // Context FSM
  // --------------------------------------------------

  // Hold off while a record waits to be written, keeps the FIFO from overrun
  assign ctx.tready = fifo_in_ready && !push_q;
  assign ctx_beat   = ctx.tvalid && ctx.tready;

  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      state  <= CTX_HEADER;
      push_q <= 1'b0;
    end else begin
      push_q <= 1'b0;
      if (ctx_beat) begin
        case (state)
          CTX_HEADER: begin
            // Flags come straight out of the header
            eob_q      <= ctx.tdata[57];
            eov_q      <= ctx.tdata[56];
            has_time_q <= hdr_has_time(ctx.tdata);
            if (hdr_has_time(ctx.tdata) && !ctx.tlast) begin
              state <= CTX_TIMESTAMP;
            end else begin
              // Nothing more needed for the record
              push_q <= 1'b1;
              if (!ctx.tlast) begin
                state <= CTX_METADATA;
              end
            end
          end
          CTX_TIMESTAMP: begin
            ts_q   <= ctx.tdata;
            push_q <= 1'b1;
            state  <= ctx.tlast ? CTX_HEADER : CTX_METADATA;
          end
          default: begin
            // Metadata words are consumed and thrown away
            if (ctx.tlast) begin
              state <= CTX_HEADER;
            end
          end
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Sideband buffer
  // --------------------------------------------------

  sideband_fifo #(
    .DEPTH (`CTX_FIFO_DEPTH)
  ) u_sideband_fifo (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .i_timestamp   (ts_q),
    .i_has_time    (has_time_q),
    .i_eov         (eov_q),
    .i_eob         (eob_q),
    .i_valid       (push_q),
    .i_ready       (fifo_in_ready),
    .o_timestamp   (out.timestamp),
    .o_has_time    (out.has_time),
    .o_eov         (out.eov),
    .o_eob         (out.eob),
    .o_valid       (fifo_out_valid),
    .o_ready       (fifo_pop)
  );

  // --------------------------------------------------
  // Payload release
  // --------------------------------------------------

  // Payload only moves once its sideband is at the FIFO head
  assign pay.tready = out.tready && fifo_out_valid;
  assign out.tvalid = pay.tvalid && fifo_out_valid;

  // Record retires with the last payload beat
  assign fifo_pop = pay.tvalid && pay.tready && pay.tlast;

  assign out.tdata = pay.tdata;
  assign out.tkeep = pay.tkeep;
  assign out.tlast = pay.tlast;

endmodule

/* source/port_output_arbiter.sv */
/* Packet-level round robin; a granted port keeps the output until its tlast
   transfers. Assumes NUM_PORTS equals 2**PORT_W so the pointer wraps. */

`timescale 1ns/1ps
`include "chdr_rx_consts.svh"

module port_output_arbiter import chdr_rx_pkg::*; (
  input  logic       axis_data_clk,
  input  logic       axis_data_rst,
  sideband_if.sink   in [`NUM_PORTS],
  output chdr_word_t m_tdata,
  output item_keep_t m_tkeep,
  output logic       m_tlast,
  output logic       m_tvalid,
  input  logic       m_tready,
  output port_idx_t  m_port,
  output timestamp_t m_timestamp,
  output logic       m_has_time,
  output logic       m_eov,
  output logic       m_eob
);

  // Per-port copies so the mux can use a variable index
  chdr_word_t v_tdata [`NUM_PORTS];
  item_keep_t v_tkeep [`NUM_PORTS];
  timestamp_t v_ts    [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] v_tlast;
  logic [`NUM_PORTS-1:0] v_tvalid;
  logic [`NUM_PORTS-1:0] v_has_time;
  logic [`NUM_PORTS-1:0] v_eov;
  logic [`NUM_PORTS-1:0] v_eob;

  port_idx_t rr_ptr;
  port_idx_t grant_q;
  logic      locked;
  port_idx_t search;
  port_idx_t grant;

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
    assign v_tdata[p]    = in[p].tdata;
    assign v_tkeep[p]    = in[p].tkeep;
    assign v_tlast[p]    = in[p].tlast;
    assign v_tvalid[p]   = in[p].tvalid;
    assign v_ts[p]       = in[p].timestamp;
    assign v_has_time[p] = in[p].has_time;
    assign v_eov[p]      = in[p].eov;
    assign v_eob[p]      = in[p].eob;
    // Only the granted port sees ready
    assign in[p].tready  = m_tready && (grant == port_idx_t'(p));
  end

  // First valid port at or after the pointer, nearest wins
  always_comb begin : rr_search
    port_idx_t idx;
    search = rr_ptr;
    for (int i = `NUM_PORTS - 1; i >= 0; i--) begin
      idx = rr_ptr + port_idx_t'(i);
      if (v_tvalid[idx]) begin
        search = idx;
      end
    end
  end

  assign grant = locked ? grant_q : search;

  assign m_tdata     = v_tdata[grant];
  assign m_tkeep     = v_tkeep[grant];
  assign m_tlast     = v_tlast[grant];
  assign m_tvalid    = v_tvalid[grant];
  assign m_port      = grant;
  assign m_timestamp = v_ts[grant];
  assign m_has_time  = v_has_time[grant];
  assign m_eov       = v_eov[grant];
  assign m_eob       = v_eob[grant];

  // Lock as soon as a beat is offered so valid stays put
  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      rr_ptr <= '0;
      locked <= 1'b0;
    end else if (m_tvalid && m_tready && m_tlast) begin
      locked <= 1'b0;
      rr_ptr <= grant + port_idx_t'(1);
    end else if (m_tvalid) begin
      locked  <= 1'b1;
      grant_q <= grant;
    end
  end

  // Port cannot switch while a packet is in flight
  a_grant_held: assert property (@(posedge axis_data_clk) disable iff (axis_data_rst)
    (m_tvalid && !(m_tready && m_tlast)) |=> (m_tvalid && m_port == $past(m_port)))
    else $error("arbiter grant changed mid-packet");

endmodule

/* source/chdr_rx_top.sv */
/* Four-port CHDR receive path, 64-bit words only. Every packet needs a
   non-empty payload; lengths and packet types are not checked. */

`timescale 1ns/1ps
`include "chdr_rx_consts.svh"

module chdr_rx_top import chdr_rx_pkg::*; (
  input  logic       axis_data_clk,
  input  logic       axis_data_rst,
  input  chdr_word_t s_chdr_tdata,
  input  logic       s_chdr_tlast,
  input  logic       s_chdr_tvalid,
  output logic       s_chdr_tready,
  output chdr_word_t m_tdata,
  output item_keep_t m_tkeep,
  output logic       m_tlast,
  output logic       m_tvalid,
  input  logic       m_tready,
  output port_idx_t  m_port,
  output timestamp_t m_timestamp,
  output logic       m_has_time,
  output logic       m_eov,
  output logic       m_eob
);

  // Per-port buses
  context_if  ctx_bus [`NUM_PORTS] ();
  payload_if  pay_bus [`NUM_PORTS] ();
  sideband_if sb_bus  [`NUM_PORTS] ();

  chdr_port_router u_router (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .s_tdata       (s_chdr_tdata),
    .s_tlast       (s_chdr_tlast),
    .s_tvalid      (s_chdr_tvalid),
    .s_tready      (s_chdr_tready),
    .ctx           (ctx_bus),
    .pay           (pay_bus)
  );

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_parser
    context_parser u_parser (
      .axis_data_clk (axis_data_clk),
      .axis_data_rst (axis_data_rst),
      .ctx           (ctx_bus[p]),
      .pay           (pay_bus[p]),
      .out           (sb_bus[p])
    );
  end

  port_output_arbiter u_arbiter (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .in            (sb_bus),
    .m_tdata       (m_tdata),
    .m_tkeep       (m_tkeep),
    .m_tlast       (m_tlast),
    .m_tvalid      (m_tvalid),
    .m_tready      (m_tready),
    .m_port        (m_port),
    .m_timestamp   (m_timestamp),
    .m_has_time    (m_has_time),
    .m_eov         (m_eov),
    .m_eob         (m_eob)
  );

endmodule

/* verification/chdr_rx_tb.sv */
/* Directed tests of the CHDR receive path. Output order is checked per port only,
   and the timestamp is compared only on packets that carry one. */

`timescale 1ns/1ps
`include "chdr_rx_consts.svh"

module chdr_rx_tb import chdr_rx_pkg::*; ();

  // One expected output beat with its sideband
  typedef struct packed {
    port_idx_t  port;
    chdr_word_t data;
    item_keep_t keep;
    logic       last;
    timestamp_t ts;
    logic       has_time;
    logic       eov;
    logic       eob;
  } exp_beat_t;

  logic       axis_data_clk;
  logic       axis_data_rst;
  chdr_word_t s_chdr_tdata;
  logic       s_chdr_tlast;
  logic       s_chdr_tvalid;
  logic       s_chdr_tready;
  chdr_word_t m_tdata;
  item_keep_t m_tkeep;
  logic       m_tlast;
  logic       m_tvalid;
  logic       m_tready;
  port_idx_t  m_port;
  timestamp_t m_timestamp;
  logic       m_has_time;
  logic       m_eov;
  logic       m_eob;

  chdr_word_t in_data_q [$];
  logic       in_last_q [$];
  exp_beat_t  exp_q [$];

  string test_name = "reset";
  int    errors = 0;
  int    checks = 0;
  int    pkt_id = 0;
  int    cycles = 0;
  int    cycle_limit = 200;
  int    seed = 61;
  logic  bp_en = 1'b0;

  chdr_rx_top u_chdr_rx_top (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .s_chdr_tdata  (s_chdr_tdata),
    .s_chdr_tlast  (s_chdr_tlast),
    .s_chdr_tvalid (s_chdr_tvalid),
    .s_chdr_tready (s_chdr_tready),
    .m_tdata       (m_tdata),
    .m_tkeep       (m_tkeep),
    .m_tlast       (m_tlast),
    .m_tvalid      (m_tvalid),
    .m_tready      (m_tready),
    .m_port        (m_port),
    .m_timestamp   (m_timestamp),
    .m_has_time    (m_has_time),
    .m_eov         (m_eov),
    .m_eob         (m_eob)
  );

  // 8 ns clock
  always #4 axis_data_clk = ~axis_data_clk;

  // Random output ready while back-pressure is on
  always @(posedge axis_data_clk) begin : ready_driver
    int r;
    #1;
    r = $random(seed);
    m_tready = bp_en ? r[0] : 1'b1;
  end

  // Watchdog whose limit grows with every packet built
  always @(posedge axis_data_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles with %0d output beats still expected",
               cycles, exp_q.size());
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------

  task automatic check_word(string field, chdr_word_t exp, chdr_word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, field, exp, act);
    end
  endtask

  task automatic check_keep(string field, item_keep_t exp, item_keep_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, field, exp, act);
    end
  endtask

  task automatic check_timestamp(string field, timestamp_t exp, timestamp_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, field, exp, act);
    end
  endtask

  task automatic check_port(string field, port_idx_t exp, port_idx_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, field, exp, act);
    end
  endtask

  task automatic check_flags(string field, logic exp, logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, field, exp, act);
    end
  endtask

  // Sampled mid-cycle where every output is settled; the beat moves on the next edge
  always @(negedge axis_data_clk) begin : out_monitor
    int idx;
    exp_beat_t e;
    port_idx_t tag_port;
    if (!axis_data_rst && m_tvalid && m_tready) begin
      // Payload words carry the port they were sent to in their top bits
      tag_port = port_idx_t'(m_tdata[`CHDR_W-1 -: `PORT_W]);
      idx = -1;
      for (int i = exp_q.size() - 1; i >= 0; i--) begin
        if (exp_q[i].port == tag_port) begin
          idx = i;
        end
      end
      if (idx < 0) begin
        errors++;
        $display("Unexpected output beat on port %0d in test %s, data %h",
                 m_port, test_name, m_tdata);
      end else begin
        e = exp_q[idx];
        exp_q.delete(idx);
        check_port("m_port", e.port, m_port);
        check_word("m_tdata", e.data, m_tdata);
        check_keep("m_tkeep", e.keep, m_tkeep);
        check_flags("m_tlast", e.last, m_tlast);
        check_flags("m_has_time", e.has_time, m_has_time);
        check_flags("m_eov", e.eov, m_eov);
        check_flags("m_eob", e.eob, m_eob);
        if (e.has_time) begin
          check_timestamp("m_timestamp", e.ts, m_timestamp);
        end
      end
    end
  end

  // --------------------------------------------------
  // Packet builder and stream driver
  // --------------------------------------------------

  // Header, optional timestamp, metadata, then nwords payload words
  task automatic build_packet(port_idx_t port, logic with_ts, timestamp_t ts,
                              num_mdata_t nmdata, logic eov, logic eob, int nwords,
                              logic half_last);
    chdr_word_t hdr;
    chdr_word_t w;
    chdr_len_t  len;
    exp_beat_t  e;
    item_keep_t last_keep;
    int         ctx_words;
    int         tail;
    int         samples;
    ctx_words = 1 + int'(with_ts) + int'(nmdata);
    len = chdr_len_t'(8 * (ctx_words + nwords) - (half_last ? 4 : 0));
    // Samples present in the final word, from the byte length
    tail = int'(len) % 8;
    samples = (tail == 0) ? `NIPC : (tail + 3) / 4;
    last_keep = item_keep_t'((1 << samples) - 1);
    hdr = '0;
    hdr[57] = eob;
    hdr[56] = eov;
    hdr[55:53] = with_ts ? pkt_type_t'(7) : pkt_type_t'(6);
    hdr[52:48] = nmdata;
    hdr[47:32] = 16'(pkt_id);
    hdr[31:16] = len;
    // Upper endpoint bits set so only the low bits may pick the port
    hdr[15:0] = {14'h0011, port};
    in_data_q.push_back(hdr);
    in_last_q.push_back(1'b0);
    if (with_ts) begin
      in_data_q.push_back(ts);
      in_last_q.push_back(1'b0);
    end
    for (int m = 0; m < int'(nmdata); m++) begin
      in_data_q.push_back({16'hBAD0, 16'(pkt_id), 32'(m)});
      in_last_q.push_back(1'b0);
    end
    for (int b = 0; b < nwords; b++) begin
      w = {port, 14'h1A5, 16'(pkt_id), 32'(b)};
      in_data_q.push_back(w);
      in_last_q.push_back(b == nwords - 1);
      e.port = port;
      e.data = w;
      e.keep = (b == nwords - 1) ? last_keep : '1;
      e.last = (b == nwords - 1);
      e.ts = ts;
      e.has_time = with_ts;
      e.eov = eov;
      e.eob = eob;
      exp_q.push_back(e);
    end
    cycle_limit += 4 * (ctx_words + 2 * nwords);
    pkt_id++;
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic drive_stream();
    logic done;
    while (in_data_q.size() > 0) begin
      s_chdr_tdata = in_data_q.pop_front();
      s_chdr_tlast = in_last_q.pop_front();
      s_chdr_tvalid = 1'b1;
      done = 1'b0;
      while (!done) begin
        @(negedge axis_data_clk);
        done = s_chdr_tready;
        @(posedge axis_data_clk);
        #1;
      end
    end
    s_chdr_tvalid = 1'b0;
    s_chdr_tlast = 1'b0;
  endtask

  task automatic wait_drain(int limit);
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < limit) begin
      @(posedge axis_data_clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d output beats never arrived in test %s", exp_q.size(), test_name);
      exp_q.delete();
    end
    // Idle gap so a stray extra beat lands in this test
    repeat (4) @(posedge axis_data_clk);
    #1;
  endtask

  task automatic run_traffic();
    int limit;
    limit = 4 * (in_data_q.size() + exp_q.size()) + 100;
    drive_stream();
    wait_drain(limit);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------

  task automatic test_no_time_eov();
    test_name = "no_time_eov";
    build_packet(port_idx_t'(1), 1'b0, '0, num_mdata_t'(0), 1'b1, 1'b0, 4, 1'b0);
    run_traffic();
  endtask

  task automatic test_time_mdata();
    test_name = "time_mdata";
    build_packet(port_idx_t'(2), 1'b1, 64'h0123_4567_89AB_CDEF, num_mdata_t'(3),
                 1'b0, 1'b1, 3, 1'b0);
    run_traffic();
  endtask

  task automatic test_half_word();
    test_name = "half_word";
    build_packet(port_idx_t'(3), 1'b0, '0, num_mdata_t'(0), 1'b0, 1'b0, 3, 1'b1);
    // Single beat that is both first and last
    build_packet(port_idx_t'(0), 1'b1, 64'h0000_0000_0000_0F00, num_mdata_t'(1),
                 1'b1, 1'b1, 1, 1'b1);
    run_traffic();
  endtask

  task automatic test_back_pressure();
    test_name = "back_pressure";
    bp_en = 1'b1;
    for (int i = 0; i < 8; i++) begin
      build_packet(port_idx_t'(i), (i % 2) == 1, {32'hFACE_0000, 32'(i)},
                   num_mdata_t'(i % 3), (i % 3) == 0, (i % 4) == 1, 1 + i % 5,
                   (i % 4) == 2);
    end
    run_traffic();
    bp_en = 1'b0;
  endtask

  task automatic test_interleave();
    test_name = "interleave";
    // More back-to-back packets on one port than the sideband FIFO holds
    for (int i = 0; i < `CTX_FIFO_DEPTH + 2; i++) begin
      build_packet(port_idx_t'(2), (i % 2) == 0, {32'h7700_0000, 32'(i)},
                   num_mdata_t'(0), 1'b1, (i % 3) == 2, 2, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      build_packet(port_idx_t'(3 - i % 4), (i % 3) == 1, {32'h5500_0000, 32'(i)},
                   num_mdata_t'(i % 2), (i % 2) == 1, 1'b0, 1 + i % 3, (i % 5) == 4);
    end
    run_traffic();
  endtask

  initial begin
    axis_data_clk = 1'b0;
    axis_data_rst = 1'b1;
    s_chdr_tdata = '0;
    s_chdr_tlast = 1'b0;
    s_chdr_tvalid = 1'b0;
    m_tready = 1'b1;
    repeat (10) @(posedge axis_data_clk);
    #1;
    axis_data_rst = 1'b0;

    test_no_time_eov();
    test_time_mdata();
    test_half_word();
    test_back_pressure();
    test_interleave();

    $display("Finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+source
source/chdr_rx_pkg.sv
source/stream_ifs.sv
source/chdr_port_router.sv
source/sideband_fifo.sv
source/context_parser.sv
source/port_output_arbiter.sv
source/chdr_rx_top.sv
verification/chdr_rx_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := chdr_rx_tb
FILELIST   := filelist.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
